// ==== src/uart_consts.svh ====
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// ***************************************************************************
// serial frame timing
// ***************************************************************************

// clock cycles spent on each serial bit.
// 16 keeps simulation short; a real link derives this from the clock and baud.
`define UART_CLKS_PER_BIT 16

// data bits carried by one frame, sent LSB first.
`define UART_DATA_BITS 8

// ***************************************************************************
// transmit queue
// ***************************************************************************

// number of byte slots in the transmit queue.
// The host owns one credit per slot after reset, so this is also the
// initial host credit count.
`define UART_FIFO_DEPTH 4

// the pointer and count types in uartPkg assume a power-of-two depth.
// a depth of 4 gives 2-bit pointers that wrap on their own and a 3-bit
// occupancy that can hold the full value.

`endif

// ==== src/uartPkg.sv ====
`include "uart_consts.svh"

package uartPkg;

    // ***********************************************************************
    // widths
    // ***********************************************************************
    typedef logic [`UART_DATA_BITS-1:0]          byteT;    // one data byte.
    typedef logic [$clog2(`UART_DATA_BITS)-1:0]  bitIdxT;  // current data bit.
    typedef logic [7:0]                          baudCntT; // cycles within a bit.

    typedef logic [$clog2(`UART_FIFO_DEPTH)-1:0] fifoPtrT; // wraps at the depth.
    typedef logic [$clog2(`UART_FIFO_DEPTH):0]   fifoCntT; // 0 up to the depth.

    // ***********************************************************************
    // state machines
    // ***********************************************************************
    typedef enum logic [2:0] {
        TX_IDLE, TX_START, TX_DATA, TX_STOP,
        TX_TURN // one cycle after the stop bit that returns the credit.
    } txStateT;

    typedef enum logic [2:0] {
        RX_IDLE, RX_START, RX_DATA, RX_STOP,
        RX_DELIVER // byte and error flag are shown for this one cycle.
    } rxStateT;

endpackage

// ==== src/txFifo.sv ====
`timescale 1ns/1ps
`include "uart_consts.svh"

module txFifo import uartPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic hostValid,
    input  byteT hostData,
    output logic hostCredit,
    output logic txValid,
    output byteT txData,
    input  logic txCredit
);

    localparam fifoCntT FULL_CNT = fifoCntT'(`UART_FIFO_DEPTH);

    byteT    mem [`UART_FIFO_DEPTH];
    fifoPtrT wrPtr;
    fifoPtrT rdPtr;
    fifoCntT count;
    logic    txCreditHeld; // the single credit granted by the transmitter.
    logic    push;
    logic    pop;

    // a write into a full queue is a host error and is dropped without a credit.
    assign push = hostValid && (count != FULL_CNT);

    // pop whenever the transmitter can take a byte and one is waiting.
    assign pop = txCreditHeld && (count != '0);

    assign txValid    = pop;
    assign txData     = mem[rdPtr];
    assign hostCredit = pop; // the popped slot goes back to the host.

    // ***********************************************************************
    // storage
    // ***********************************************************************
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= hostData;
        end
    end

    // ***********************************************************************
    // pointers, occupancy and downstream credit
    // ***********************************************************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle, or a push and pop together.
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            txCreditHeld <= 1'b1; // the transmitter starts out able to accept a byte.
        end else if (txCredit) begin
            txCreditHeld <= 1'b1;
        end else if (pop) begin
            txCreditHeld <= 1'b0;
        end
    end

    // the transmitter only returns its credit after a pop, so the set and
    // the clear above never meet in the same cycle.

endmodule

// ==== src/uartTx.sv ====
`timescale 1ns/1ps
`include "uart_consts.svh"

module uartTx import uartPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic txValid,
    input  byteT txData,
    output logic txCredit,
    output logic txSerial
);

    localparam baudCntT BIT_LAST = baudCntT'(`UART_CLKS_PER_BIT - 1);
    localparam bitIdxT  IDX_LAST = bitIdxT'(`UART_DATA_BITS - 1);

    txStateT state;
    baudCntT baudCnt;
    bitIdxT  bitIdx;
    byteT    shiftReg; // bit 0 is always the next data bit to send.
    logic    txLine;
    logic    bitDone;

    assign bitDone  = (baudCnt == BIT_LAST);
    assign txSerial = txLine;
    assign txCredit = (state == TX_TURN);

    // ***********************************************************************
    // data byte
    // ***********************************************************************
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && txValid) begin
            shiftReg <= txData;
        end else if (state == TX_DATA && bitDone) begin
            shiftReg <= shiftReg >> 1;
        end
    end

    // ***********************************************************************
    // frame sequencer
    // ***********************************************************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= TX_IDLE;
            baudCnt <= '0;
            bitIdx  <= '0;
            txLine  <= 1'b1; // line idles high.
        end else begin
            case (state)
                TX_IDLE: begin
                    if (txValid) begin
                        state   <= TX_START;
                        baudCnt <= '0;
                        txLine  <= 1'b0; // start bit begins on the next cycle.
                    end
                end
                TX_START: begin
                    if (bitDone) begin
                        state   <= TX_DATA;
                        baudCnt <= '0;
                        bitIdx  <= '0;
                        txLine  <= shiftReg[0];
                    end else begin
                        baudCnt <= baudCnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bitDone) begin
                        baudCnt <= '0;
                        if (bitIdx == IDX_LAST) begin
                            state  <= TX_STOP;
                            txLine <= 1'b1;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                            txLine <= shiftReg[1]; // bit 0 leaves on this same edge.
                        end
                    end else begin
                        baudCnt <= baudCnt + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (bitDone) begin
                        state   <= TX_TURN;
                        baudCnt <= '0;
                    end else begin
                        baudCnt <= baudCnt + 1'b1;
                    end
                end
                TX_TURN: begin
                    state <= TX_IDLE; // line stays high through this cycle.
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== src/uartRx.sv ====
`timescale 1ns/1ps
`include "uart_consts.svh"

module uartRx import uartPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic rxSerial,
    output logic rxValid,
    output byteT rxData,
    output logic rxFrameError
);

    localparam baudCntT BIT_LAST  = baudCntT'(`UART_CLKS_PER_BIT - 1);
    localparam baudCntT HALF_LAST = baudCntT'(`UART_CLKS_PER_BIT / 2 - 1);
    localparam bitIdxT  IDX_LAST  = bitIdxT'(`UART_DATA_BITS - 1);

    logic    syncMeta;
    logic    syncLine;
    logic    linePrev; // last synchronized value, for edge detection.
    logic    fallEdge;
    rxStateT state;
    baudCntT baudCnt;
    bitIdxT  bitIdx;
    byteT    shiftReg;
    logic    stopErr;
    logic    bitDone;

    assign fallEdge = linePrev && !syncLine;
    assign bitDone  = (baudCnt == BIT_LAST);

    assign rxValid      = (state == RX_DELIVER);
    assign rxData       = shiftReg;
    assign rxFrameError = stopErr && rxValid;

    // ***********************************************************************
    // input synchronizer
    // ***********************************************************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            syncMeta <= 1'b1;
            syncLine <= 1'b1;
            linePrev <= 1'b1; // no false start edge right after reset.
        end else begin
            syncMeta <= rxSerial;
            syncLine <= syncMeta;
            linePrev <= syncLine;
        end
    end

    // data bits arrive LSB first, so each new sample enters at the top.
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bitDone) begin
            shiftReg <= {syncLine, shiftReg[$bits(byteT)-1:1]};
        end
    end

    // ***********************************************************************
    // frame sequencer
    // ***********************************************************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= RX_IDLE;
            baudCnt <= '0;
            bitIdx  <= '0;
            stopErr <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (fallEdge) begin
                        state   <= RX_START;
                        baudCnt <= '0;
                    end
                end
                RX_START: begin
                    // half a bit in, the start bit must still be low.
                    if (baudCnt == HALF_LAST) begin
                        baudCnt <= '0;
                        bitIdx  <= '0;
                        state   <= syncLine ? RX_IDLE : RX_DATA; // high means a glitch.
                    end else begin
                        baudCnt <= baudCnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bitDone) begin
                        baudCnt <= '0;
                        if (bitIdx == IDX_LAST) begin
                            state <= RX_STOP;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                        end
                    end else begin
                        baudCnt <= baudCnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bitDone) begin
                        state   <= RX_DELIVER;
                        baudCnt <= '0;
                        stopErr <= !syncLine; // a low stop bit is a framing error.
                    end else begin
                        baudCnt <= baudCnt + 1'b1;
                    end
                end
                RX_DELIVER: begin
                    state <= RX_IDLE;
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== src/uartCore.sv ====
`timescale 1ns/1ps

module uartCore import uartPkg::*; (
    input  logic clk,
    input  logic rstN,

    // host transmit side, credit based.
    input  logic hostValid,
    input  byteT hostData,
    output logic hostCredit,

    // serial lines.
    output logic txSerial,
    input  logic rxSerial,

    // received bytes, one cycle each.
    output logic rxValid,
    output byteT rxData,
    output logic rxFrameError
);

    // ***********************************************************************
    // transmit path
    // ***********************************************************************
    logic txValid;
    byteT txData;
    logic txCredit;

    txFifo uTxFifo (
        .clk        (clk),
        .rstN       (rstN),
        .hostValid  (hostValid),
        .hostData   (hostData),
        .hostCredit (hostCredit),
        .txValid    (txValid),
        .txData     (txData),
        .txCredit   (txCredit)
    );

    uartTx uUartTx (
        .clk      (clk),
        .rstN     (rstN),
        .txValid  (txValid),
        .txData   (txData),
        .txCredit (txCredit),
        .txSerial (txSerial)
    );

    // ***********************************************************************
    // receive path, independent of the transmitter.
    // ***********************************************************************
    uartRx uUartRx (
        .clk          (clk),
        .rstN         (rstN),
        .rxSerial     (rxSerial),
        .rxValid      (rxValid),
        .rxData       (rxData),
        .rxFrameError (rxFrameError)
    );

endmodule

// ==== tests/uartCoreTb.sv ====
`timescale 1ns/1ps
`include "uart_consts.svh"

module uartCoreTb import uartPkg::*; ();

    localparam int BIT_CLKS  = `UART_CLKS_PER_BIT;
    localparam int DEPTH     = `UART_FIFO_DEPTH;
    localparam int STOP_IDX  = `UART_DATA_BITS + 1;
    localparam int PERIOD    = 20;
    localparam int DRIVE_DLY = 2;

    logic clk;
    logic rstN;
    logic hostValid;
    byteT hostData;
    logic hostCredit;
    logic txSerial;
    logic rxValid;
    byteT rxData;
    logic rxFrameError;
    logic loopSel; // rxSerial follows txSerial when set.
    logic forcedLine;

    int         credits = DEPTH;
    int         creditPulses = 0;
    int         bytesWritten = 0;
    integer     seed = 54;
    byteT       txExpQ[$];
    logic [8:0] rxExpQ[$]; // frame error flag above the byte.
    logic [8:0] rxExp;
    logic       monActive;
    logic       monPrev;
    logic       monExp;
    int         monCnt;
    int         monBit;
    byteT       monByte;
    byte        vecKind[$];
    byteT       vecByte[$];
    logic       vecStop[$];
    int         vecGlitch[$];
    logic       vecErr[$];

    uartCore dut (
        .clk          (clk),
        .rstN         (rstN),
        .hostValid    (hostValid),
        .hostData     (hostData),
        .hostCredit   (hostCredit),
        .txSerial     (txSerial),
        .rxSerial     (loopSel ? txSerial : forcedLine),
        .rxValid      (rxValid),
        .rxData       (rxData),
        .rxFrameError (rxFrameError)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // ***********************************************************************
    // helpers
    // ***********************************************************************
    task automatic stopOnFailure(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else
            stopOnFailure($sformatf("** Error at %0t ns: %s is %0h, expected %0h",
                                    $time, what, got, exp));
    endtask

    task automatic nextDriveSlot();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic checkIdleOutputs();
        checkValue("txSerial", txSerial, 1'b1);
        checkValue("hostCredit", hostCredit, 1'b0);
        checkValue("rxValid", rxValid, 1'b0);
        checkValue("rxFrameError", rxFrameError, 1'b0);
    endtask

    task automatic waitForCredit();
        int cycles;
        cycles = 0;
        while (credits == 0) begin
            nextDriveSlot();
            cycles++;
            if (cycles > 400) stopOnFailure("timed out waiting for a host credit");
        end
    endtask

    // returns once every queued byte has been seen on the line and at the receiver.
    task automatic waitForDrain();
        int cycles;
        cycles = 0;
        while (rxExpQ.size() != 0 || txExpQ.size() != 0 || monActive) begin
            nextDriveSlot();
            cycles++;
            if (cycles > 1200) stopOnFailure("timed out waiting for queued bytes to arrive");
        end
        checkValue("host credits after drain", credits, DEPTH);
    endtask

    task automatic sendByte(input byteT value, input logic expErr);
        int gap;
        if (credits == 0) begin
            waitForCredit();
            gap = $unsigned($random(seed)) % 8; // pause before the next burst.
            repeat (gap) nextDriveSlot();
        end
        hostValid = 1'b1;
        hostData  = value;
        credits--;
        bytesWritten++;
        txExpQ.push_back(value);
        rxExpQ.push_back({expErr, value});
        nextDriveSlot();
        hostValid = 1'b0;
    endtask

    task automatic driveFrame(input byteT value, input logic stopBit, input logic expErr);
        logic [9:0] frame;
        frame = {stopBit, value, 1'b0};
        rxExpQ.push_back({expErr, value});
        for (int i = 0; i < 10; i++) begin
            forcedLine = frame[i];
            repeat (BIT_CLKS) nextDriveSlot();
        end
        forcedLine = 1'b1;
        waitForDrain();
        repeat (BIT_CLKS) nextDriveSlot(); // idle line before the next case.
    endtask

    // an rxValid in the quiet time is caught by the receive checker.
    task automatic driveGlitch(input int len);
        checkValue("glitch shorter than half a bit", len < BIT_CLKS / 2, 1'b1);
        forcedLine = 1'b0;
        repeat (len) nextDriveSlot();
        forcedLine = 1'b1;
        repeat (2 * BIT_CLKS) nextDriveSlot();
    endtask

    task automatic readVectors();
        int    fd;
        int    fields;
        string line;
        byte   kind;
        int    value;
        int    stopBit;
        int    glitchLen;
        int    expErr;
        fd = $fopen("tests/uart_vectors.txt", "r");
        if (fd == 0) begin
            stopOnFailure("could not open tests/uart_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                fields = $sscanf(line, "%c %h %d %d %d", kind, value, stopBit, glitchLen,
                                 expErr);
                if (fields == 5 && kind != "#") begin
                    vecKind.push_back(kind);
                    vecByte.push_back(value[7:0]);
                    vecStop.push_back(stopBit[0]);
                    vecGlitch.push_back(glitchLen);
                    vecErr.push_back(expErr[0]);
                end
            end
            $fclose(fd);
        end
    endtask

    // ***********************************************************************
    // monitors sampling on the falling edge
    // ***********************************************************************
    always @(negedge clk) begin
        if (rstN && hostCredit) begin
            credits++;
            creditPulses++;
            checkValue("host credits within queue depth", credits <= DEPTH, 1'b1);
        end
    end

    always @(negedge clk) begin
        if (!rstN) begin
            monActive = 1'b0;
            monPrev   = 1'b1;
        end else if (!monActive) begin
            if (monPrev && !txSerial) begin // start of a frame.
                checkValue("bytes waiting at a frame start", txExpQ.size() > 0, 1'b1);
                monByte   = txExpQ.pop_front();
                monActive = 1'b1;
                monCnt    = 0;
            end
            monPrev = txSerial;
        end else begin
            monCnt++;
            if (monCnt % BIT_CLKS == BIT_CLKS / 2) begin
                monBit = monCnt / BIT_CLKS;
                monExp = (monBit == 0) ? 1'b0 :
                         (monBit == STOP_IDX) ? 1'b1 : monByte[monBit - 1];
                checkValue($sformatf("txSerial bit %0d", monBit), txSerial, monExp);
                if (monBit == STOP_IDX) begin
                    monActive = 1'b0;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rstN && rxValid) begin
            checkValue("bytes expected at rxValid", rxExpQ.size() > 0, 1'b1);
            rxExp = rxExpQ.pop_front();
            checkValue("rxData", rxData, rxExp[7:0]);
            checkValue("rxFrameError", rxFrameError, rxExp[8]);
        end
    end

    // ***********************************************************************
    // main sequence
    // ***********************************************************************
    initial begin
        hostValid  = 1'b0;
        hostData   = '0;
        loopSel    = 1'b1;
        forcedLine = 1'b1;
        rstN       = 1'b0;
        repeat (16) begin
            @(negedge clk);
            checkIdleOutputs();
        end
        nextDriveSlot();
        rstN = 1'b1;
        @(negedge clk);
        checkIdleOutputs();
        nextDriveSlot();
        readVectors();
        for (int i = 0; i < vecKind.size(); i++) begin
            if (vecKind[i] == "L") begin
                loopSel = 1'b1;
                sendByte(vecByte[i], vecErr[i]);
            end else begin
                waitForDrain();
                loopSel = 1'b0;
                if (vecKind[i] == "F") begin
                    driveFrame(vecByte[i], vecStop[i], vecErr[i]);
                end else if (vecKind[i] == "G") begin
                    driveGlitch(vecGlitch[i]);
                end else begin
                    stopOnFailure($sformatf("unknown kind on vector line %0d", i));
                end
            end
        end
        waitForDrain();
        checkValue("hostCredit pulses", creditPulses, bytesWritten);
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== tests/uart_vectors.txt ====
# kind byte stopBit glitchLen expErr
# kind: L loopback, F forced frame, G glitch; byte in hex, glitch length in cycles
L 3C 1 0 0
L A5 1 0 0
L 00 1 0 0
L FF 1 0 0
L 81 1 0 0
L 7E 1 0 0
F C3 0 0 1
F 96 1 0 0
G 00 1 3 0
F 5A 1 0 0
G 00 1 7 0
L 12 1 0 0
L 34 1 0 0
L 56 1 0 0
G 00 1 1 0
F 00 0 0 1
F FF 0 0 1
G 00 1 5 0
L E7 1 0 0
L 01 1 0 0
L 80 1 0 0
L 6D 1 0 0

// ==== build.f ====
+incdir+src
src/uartPkg.sv
src/txFifo.sv
src/uartTx.sv
src/uartRx.sv
src/uartCore.sv
tests/uartCoreTb.sv

// ==== Bender.yml ====
package:
  name: uart_core

sources:
  - include_dirs:
      - src
    files:
      - src/uartPkg.sv
      - src/txFifo.sv
      - src/uartTx.sv
      - src/uartRx.sv
      - src/uartCore.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/uartCoreTb.sv
